// File: hdl/ddr_apb_pkg.sv
`default_nettype none

package ddr_apb_pkg;

  // Bus widths
  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;
  localparam int APB_STRB_W = APB_DATA_W / 8;

  // Start of the memory window in the APB byte address space
  localparam logic [APB_ADDR_W-1:0] MEM_BASE = 12'h100;

  // PSLVERR response codes
  localparam logic PSLVERR_OK  = 1'b0;
  localparam logic PSLVERR_ERR = 1'b1;

  // Bytes per bus word, used to turn byte offsets into word indexes
  localparam int APB_WORD_BYTES = APB_DATA_W / 8;

endpackage : ddr_apb_pkg

`default_nettype wire

// File: hdl/ddr_regs_pkg.sv
`default_nettype none

package ddr_regs_pkg;

  // Register byte offsets
  localparam logic [ddr_apb_pkg::APB_ADDR_W-1:0] REG_ID     = 'h00;
  localparam logic [ddr_apb_pkg::APB_ADDR_W-1:0] REG_STATUS = 'h04;
  localparam logic [ddr_apb_pkg::APB_ADDR_W-1:0] REG_CTRL   = 'h08;

  // Constant returned by the identification register
  localparam logic [31:0] DDR_ID_VALUE = 32'h0DD3_0001;

  // Request bits in CTRL, read back as busy flags
  localparam int CTRL_REF_BIT = 0;
  localparam int CTRL_ZQ_BIT  = 1;

  // Read data source select from the decoder to the mux
  localparam int RD_SEL_W = 3;
  localparam logic [RD_SEL_W-1:0] RD_SEL_NONE   = 3'd0;
  localparam logic [RD_SEL_W-1:0] RD_SEL_ID     = 3'd1;
  localparam logic [RD_SEL_W-1:0] RD_SEL_STATUS = 3'd2;
  localparam logic [RD_SEL_W-1:0] RD_SEL_CTRL   = 3'd3;
  localparam logic [RD_SEL_W-1:0] RD_SEL_MEM    = 3'd4;

  // Status register layout, MSB first
  typedef struct packed {
    logic [3:0]  ref_count;
    logic [11:0] device_temp;
    logic [11:0] reserved;
    logic        zq_busy;
    logic        ref_busy;
    logic        calib_done;
    logic        pll_locked;
  } ddr_status_fields_t;

  typedef union packed {
    logic [31:0]        raw;
    ddr_status_fields_t fields;
  } ddr_status_u;

endpackage : ddr_regs_pkg

`default_nettype wire

// File: hdl/ddr_apb_slave.sv
`timescale 1ns/100ps
`default_nettype none

module ddr_apb_slave #(
  parameter int MEM_DEPTH = 64
) (
  input  logic                                  i_apb_clk,
  input  logic                                  i_rst_n,
  input  logic                                  i_psel,
  input  logic                                  i_penable,
  input  logic                                  i_pwrite,
  input  logic [ddr_apb_pkg::APB_ADDR_W-1:0]    i_paddr,
  input  logic [ddr_apb_pkg::APB_DATA_W-1:0]    i_pwdata,
  input  logic [ddr_apb_pkg::APB_STRB_W-1:0]    i_pstrb,
  input  logic                                  i_calib_done,
  output logic                                  o_pready,
  output logic                                  o_pslverr,
  output logic                                  o_mem_we,
  output logic                                  o_mem_re,
  output logic [$clog2(MEM_DEPTH)-1:0]          o_mem_idx,
  output logic [ddr_apb_pkg::APB_DATA_W-1:0]    o_mem_wdata,
  output logic [ddr_apb_pkg::APB_STRB_W-1:0]    o_mem_strb,
  output logic                                  o_ref_req,
  output logic                                  o_zq_req,
  output logic [ddr_regs_pkg::RD_SEL_W-1:0]     o_rd_sel
);

  localparam int IDX_W   = $clog2(MEM_DEPTH);
  localparam int MEM_END = int'(ddr_apb_pkg::MEM_BASE) + ddr_apb_pkg::APB_WORD_BYTES * MEM_DEPTH;

  logic                               access;
  logic                               is_id;
  logic                               is_status;
  logic                               is_ctrl;
  logic                               in_window;
  logic                               mem_ok;
  logic                               ctrl_wr;
  logic                               mem_rd_first;
  logic                               wait_q;
  logic [ddr_apb_pkg::APB_ADDR_W-1:0] mem_off;

  assign access = i_psel & i_penable;

  // Address decode
  assign is_id     = (i_paddr == ddr_regs_pkg::REG_ID);
  assign is_status = (i_paddr == ddr_regs_pkg::REG_STATUS);
  assign is_ctrl   = (i_paddr == ddr_regs_pkg::REG_CTRL);
  assign in_window = (i_paddr >= ddr_apb_pkg::MEM_BASE) && (int'(i_paddr) < MEM_END);

  // Memory window is only usable once calibration has finished
  assign mem_ok  = in_window & i_calib_done;
  assign mem_off = i_paddr - ddr_apb_pkg::MEM_BASE;

  // First access cycle of a memory read, array is sampled here
  assign mem_rd_first = access & mem_ok & ~i_pwrite & ~wait_q;

  // One wait state for memory reads
  always_ff @(posedge i_apb_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= mem_rd_first;
    end
  end

  assign o_pready  = access & (~(mem_ok & ~i_pwrite) | wait_q);
  assign o_pslverr = (access && !(is_id || is_status || is_ctrl || mem_ok)) ?
                     ddr_apb_pkg::PSLVERR_ERR : ddr_apb_pkg::PSLVERR_OK;

  // Array port
  assign o_mem_we    = access & mem_ok & i_pwrite;
  assign o_mem_re    = mem_rd_first;
  assign o_mem_idx   = mem_off[IDX_W+1:2];
  assign o_mem_wdata = i_pwdata;
  assign o_mem_strb  = i_pstrb;

  // CTRL writes complete in one cycle so these are single pulses
  assign ctrl_wr   = access & i_pwrite & is_ctrl;
  assign o_ref_req = ctrl_wr & i_pwdata[ddr_regs_pkg::CTRL_REF_BIT];
  assign o_zq_req  = ctrl_wr & i_pwdata[ddr_regs_pkg::CTRL_ZQ_BIT];

  always_comb begin
    o_rd_sel = ddr_regs_pkg::RD_SEL_NONE;
    if (access && !i_pwrite) begin
      if (is_id) begin
        o_rd_sel = ddr_regs_pkg::RD_SEL_ID;
      end else if (is_status) begin
        o_rd_sel = ddr_regs_pkg::RD_SEL_STATUS;
      end else if (is_ctrl) begin
        o_rd_sel = ddr_regs_pkg::RD_SEL_CTRL;
      end else if (mem_ok) begin
        o_rd_sel = ddr_regs_pkg::RD_SEL_MEM;
      end
    end
  end

endmodule : ddr_apb_slave

`default_nettype wire

// File: hdl/ddr_init_seq.sv
`timescale 1ns/100ps
`default_nettype none

module ddr_init_seq #(
  parameter int LOCK_CYCLES  = 16,
  parameter int CALIB_CYCLES = 64,
  parameter int REF_CYCLES   = 8,
  parameter int ZQ_CYCLES    = 16
) (
  input  logic       i_apb_clk,
  input  logic       i_rst_n,
  input  logic       i_ref_req,
  input  logic       i_zq_req,
  output logic       o_pll_locked,
  output logic       o_calib_done,
  output logic       o_ref_busy,
  output logic       o_zq_busy,
  output logic [3:0] o_ref_count
);

  localparam int INIT_MAX = (LOCK_CYCLES > CALIB_CYCLES) ? LOCK_CYCLES : CALIB_CYCLES;
  localparam int INIT_W   = $clog2(INIT_MAX + 1);
  localparam int TMR_MAX  = (REF_CYCLES > ZQ_CYCLES) ? REF_CYCLES : ZQ_CYCLES;
  localparam int TMR_W    = $clog2(TMR_MAX + 1);

  localparam logic [1:0] S_LOCK  = 2'd0;
  localparam logic [1:0] S_CALIB = 2'd1;
  localparam logic [1:0] S_READY = 2'd2;

  logic [1:0]        state_q;
  logic [INIT_W-1:0] init_cnt_q;
  logic              ready;
  logic [1:0]        req;
  logic [1:0]        busy;
  logic              ref_done;

  // Power-up sequence steps from PLL lock to calibration
  always_ff @(posedge i_apb_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q    <= S_LOCK;
      init_cnt_q <= '0;
    end else begin
      case (state_q)
        S_LOCK: begin
          if (init_cnt_q == INIT_W'(LOCK_CYCLES - 1)) begin
            state_q    <= S_CALIB;
            init_cnt_q <= '0;
          end else begin
            init_cnt_q <= init_cnt_q + 1'b1;
          end
        end
        S_CALIB: begin
          if (init_cnt_q == INIT_W'(CALIB_CYCLES - 1)) begin
            state_q    <= S_READY;
            init_cnt_q <= '0;
          end else begin
            init_cnt_q <= init_cnt_q + 1'b1;
          end
        end
        default: state_q <= S_READY;
      endcase
    end
  end

  assign ready        = (state_q == S_READY);
  assign o_pll_locked = (state_q != S_LOCK);
  assign o_calib_done = ready;

  // Channel 0 is refresh and channel 1 is ZQ calibration
  assign req = {i_zq_req, i_ref_req};

  for (genvar g = 0; g < 2; g++) begin : g_tmr
    localparam int LEN = (g == 0) ? REF_CYCLES : ZQ_CYCLES;

    logic             busy_q;
    logic [TMR_W-1:0] tmr_q;

    // Requests while busy or before calibration are dropped
    always_ff @(posedge i_apb_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        busy_q <= 1'b0;
        tmr_q  <= '0;
      end else if (busy_q) begin
        tmr_q <= tmr_q - 1'b1;
        if (tmr_q == TMR_W'(1)) begin
          busy_q <= 1'b0;
        end
      end else if (req[g] && ready) begin
        busy_q <= 1'b1;
        tmr_q  <= TMR_W'(LEN);
      end
    end

    assign busy[g] = busy_q;

    // Last busy cycle of a refresh
    if (g == 0) begin : g_ref_done
      assign ref_done = busy_q & (tmr_q == TMR_W'(1));
    end
  end

  // Completed refresh cycles wrap at 16
  always_ff @(posedge i_apb_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ref_count <= '0;
    end else if (ref_done) begin
      o_ref_count <= o_ref_count + 1'b1;
    end
  end

  assign o_ref_busy = busy[0];
  assign o_zq_busy  = busy[1];

endmodule : ddr_init_seq

`default_nettype wire

// File: hdl/ddr_mem_array.sv
`timescale 1ns/100ps
`default_nettype none

module ddr_mem_array #(
  parameter int MEM_DEPTH = 64
) (
  input  logic                               i_apb_clk,
  input  logic                               i_we,
  input  logic                               i_re,
  input  logic [$clog2(MEM_DEPTH)-1:0]       i_idx,
  input  logic [ddr_apb_pkg::APB_DATA_W-1:0] i_wdata,
  input  logic [ddr_apb_pkg::APB_STRB_W-1:0] i_strb,
  output logic [ddr_apb_pkg::APB_DATA_W-1:0] o_rdata
);

  localparam int DATA_W = ddr_apb_pkg::APB_DATA_W;
  localparam int STRB_W = ddr_apb_pkg::APB_STRB_W;

  // Stand-in for the external DDR device
  logic [DATA_W-1:0] mem [MEM_DEPTH];

  // Byte lanes are written only where the strobe is set
  always_ff @(posedge i_apb_clk) begin
    if (i_we) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_strb[b]) begin
          mem[i_idx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // Registered read, data follows one cycle after i_re
  always_ff @(posedge i_apb_clk) begin
    if (i_re) begin
      o_rdata <= mem[i_idx];
    end
  end

endmodule : ddr_mem_array

`default_nettype wire

// File: hdl/ddr_apb_rdmux.sv
`timescale 1ns/100ps
`default_nettype none

module ddr_apb_rdmux (
  input  logic                               i_apb_clk,
  input  logic                               i_rst_n,
  input  logic [ddr_regs_pkg::RD_SEL_W-1:0]  i_rd_sel,
  input  logic [ddr_apb_pkg::APB_DATA_W-1:0] i_mem_rdata,
  input  logic                               i_pll_locked,
  input  logic                               i_calib_done,
  input  logic                               i_ref_busy,
  input  logic                               i_zq_busy,
  input  logic [3:0]                         i_ref_count,
  input  logic [11:0]                        i_device_temp,
  output logic [ddr_apb_pkg::APB_DATA_W-1:0] o_prdata
);

  ddr_regs_pkg::ddr_status_u         status_d;
  logic [31:0]                       status_q;
  logic [ddr_apb_pkg::APB_DATA_W-1:0] ctrl_word;

  // Build the status word from its fields
  always_comb begin
    status_d                    = '0;
    status_d.fields.ref_count   = i_ref_count;
    status_d.fields.device_temp = i_device_temp;
    status_d.fields.zq_busy     = i_zq_busy;
    status_d.fields.ref_busy    = i_ref_busy;
    status_d.fields.calib_done  = i_calib_done;
    status_d.fields.pll_locked  = i_pll_locked;
  end

  // Sampled every cycle, also retimes the external temperature input
  always_ff @(posedge i_apb_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      status_q <= '0;
    end else begin
      status_q <= status_d.raw;
    end
  end

  always_comb begin
    ctrl_word                             = '0;
    ctrl_word[ddr_regs_pkg::CTRL_REF_BIT] = i_ref_busy;
    ctrl_word[ddr_regs_pkg::CTRL_ZQ_BIT]  = i_zq_busy;
  end

  always_comb begin
    case (i_rd_sel)
      ddr_regs_pkg::RD_SEL_ID:     o_prdata = ddr_regs_pkg::DDR_ID_VALUE;
      ddr_regs_pkg::RD_SEL_STATUS: o_prdata = status_q;
      ddr_regs_pkg::RD_SEL_CTRL:   o_prdata = ctrl_word;
      ddr_regs_pkg::RD_SEL_MEM:    o_prdata = i_mem_rdata;
      default:                     o_prdata = '0;
    endcase
  end

endmodule : ddr_apb_rdmux

`default_nettype wire

// File: hdl/ddr_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module ddr_ctrl_top #(
  parameter int MEM_DEPTH    = 64,
  parameter int LOCK_CYCLES  = 16,
  parameter int CALIB_CYCLES = 64,
  parameter int REF_CYCLES   = 8,
  parameter int ZQ_CYCLES    = 16
) (
  input  logic                               i_apb_clk,
  input  logic                               i_rst_n,
  // APB slave port
  input  logic                               i_psel,
  input  logic                               i_penable,
  input  logic                               i_pwrite,
  input  logic [ddr_apb_pkg::APB_ADDR_W-1:0] i_paddr,
  input  logic [ddr_apb_pkg::APB_DATA_W-1:0] i_pwdata,
  input  logic [ddr_apb_pkg::APB_STRB_W-1:0] i_pstrb,
  output logic [ddr_apb_pkg::APB_DATA_W-1:0] o_prdata,
  output logic                               o_pready,
  output logic                               o_pslverr,
  // Device side
  input  logic [11:0]                        i_device_temp,
  output logic                               o_init_calib_done
);

  logic                               w_mem_we;
  logic                               w_mem_re;
  logic [$clog2(MEM_DEPTH)-1:0]       wb_mem_idx;
  logic [ddr_apb_pkg::APB_DATA_W-1:0] wb_mem_wdata;
  logic [ddr_apb_pkg::APB_STRB_W-1:0] wb_mem_strb;
  logic [ddr_apb_pkg::APB_DATA_W-1:0] wb_mem_rdata;
  logic                               w_ref_req;
  logic                               w_zq_req;
  logic [ddr_regs_pkg::RD_SEL_W-1:0]  wb_rd_sel;
  logic                               w_pll_locked;
  logic                               w_calib_done;
  logic                               w_ref_busy;
  logic                               w_zq_busy;
  logic [3:0]                         wb_ref_count;

  ddr_apb_slave #(
    .MEM_DEPTH(MEM_DEPTH)
  ) slv0 (
    .i_apb_clk(i_apb_clk),
    .i_rst_n(i_rst_n),
    .i_psel(i_psel),
    .i_penable(i_penable),
    .i_pwrite(i_pwrite),
    .i_paddr(i_paddr),
    .i_pwdata(i_pwdata),
    .i_pstrb(i_pstrb),
    .i_calib_done(w_calib_done),
    .o_pready(o_pready),
    .o_pslverr(o_pslverr),
    .o_mem_we(w_mem_we),
    .o_mem_re(w_mem_re),
    .o_mem_idx(wb_mem_idx),
    .o_mem_wdata(wb_mem_wdata),
    .o_mem_strb(wb_mem_strb),
    .o_ref_req(w_ref_req),
    .o_zq_req(w_zq_req),
    .o_rd_sel(wb_rd_sel)
  );

  // Behavioral replacement for the PHY init and maintenance logic
  ddr_init_seq #(
    .LOCK_CYCLES(LOCK_CYCLES),
    .CALIB_CYCLES(CALIB_CYCLES),
    .REF_CYCLES(REF_CYCLES),
    .ZQ_CYCLES(ZQ_CYCLES)
  ) seq0 (
    .i_apb_clk(i_apb_clk),
    .i_rst_n(i_rst_n),
    .i_ref_req(w_ref_req),
    .i_zq_req(w_zq_req),
    .o_pll_locked(w_pll_locked),
    .o_calib_done(w_calib_done),
    .o_ref_busy(w_ref_busy),
    .o_zq_busy(w_zq_busy),
    .o_ref_count(wb_ref_count)
  );

  ddr_mem_array #(
    .MEM_DEPTH(MEM_DEPTH)
  ) mem0 (
    .i_apb_clk(i_apb_clk),
    .i_we(w_mem_we),
    .i_re(w_mem_re),
    .i_idx(wb_mem_idx),
    .i_wdata(wb_mem_wdata),
    .i_strb(wb_mem_strb),
    .o_rdata(wb_mem_rdata)
  );

  ddr_apb_rdmux mux0 (
    .i_apb_clk(i_apb_clk),
    .i_rst_n(i_rst_n),
    .i_rd_sel(wb_rd_sel),
    .i_mem_rdata(wb_mem_rdata),
    .i_pll_locked(w_pll_locked),
    .i_calib_done(w_calib_done),
    .i_ref_busy(w_ref_busy),
    .i_zq_busy(w_zq_busy),
    .i_ref_count(wb_ref_count),
    .i_device_temp(i_device_temp),
    .o_prdata(o_prdata)
  );

  assign o_init_calib_done = w_calib_done;

endmodule : ddr_ctrl_top

`default_nettype wire

// File: testbench/ddr_ctrl_chk.sv
`timescale 1ns/100ps
`default_nettype none

module ddr_ctrl_chk (
  input logic                               i_apb_clk,
  input logic                               i_rst_n,
  input logic                               i_psel,
  input logic                               i_penable,
  input logic [ddr_apb_pkg::APB_ADDR_W-1:0] i_paddr,
  input logic                               i_pready,
  input logic                               i_pslverr,
  input logic                               i_init_calib_done
);

  // PREADY belongs to the access phase only
  a_pready_in_access: assert property (
    @(posedge i_apb_clk) disable iff (!i_rst_n)
    i_pready |-> (i_psel && i_penable)
  ) else $error("PREADY high outside of an APB access phase");

  // Address held from setup until the transfer completes
  a_paddr_stable: assert property (
    @(posedge i_apb_clk) disable iff (!i_rst_n)
    (i_psel && !(i_penable && i_pready)) |=> $stable(i_paddr)
  ) else $error("PADDR changed before the transfer completed");

  a_pslverr_with_pready: assert property (
    @(posedge i_apb_clk) disable iff (!i_rst_n)
    i_pslverr |-> i_pready
  ) else $error("PSLVERR high without PREADY");

  // Calibration done is sticky until the next reset
  a_calib_sticky: assert property (
    @(posedge i_apb_clk) disable iff (!i_rst_n)
    i_init_calib_done |=> i_init_calib_done
  ) else $error("Calibration done dropped after it was set");

endmodule : ddr_ctrl_chk

bind ddr_ctrl_top ddr_ctrl_chk chk0 (
  .i_apb_clk(i_apb_clk),
  .i_rst_n(i_rst_n),
  .i_psel(i_psel),
  .i_penable(i_penable),
  .i_paddr(i_paddr),
  .i_pready(o_pready),
  .i_pslverr(o_pslverr),
  .i_init_calib_done(o_init_calib_done)
);

`default_nettype wire

// File: testbench/tb_ddr_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ddr_ctrl;

  localparam int MEM_DEPTH      = 64;
  localparam int LOCK_CYCLES    = 16;
  localparam int CALIB_CYCLES   = 64;
  localparam int REF_CYCLES     = 8;
  localparam int ZQ_CYCLES      = 16;
  localparam int TIMEOUT_CYCLES = 5000;
  localparam int AW = ddr_apb_pkg::APB_ADDR_W;
  localparam int DW = ddr_apb_pkg::APB_DATA_W;
  localparam int SW = ddr_apb_pkg::APB_STRB_W;

  logic          apb_clk = 1'b0;
  logic          rst_n;
  logic          psel;
  logic          penable;
  logic          pwrite;
  logic [AW-1:0] paddr;
  logic [DW-1:0] pwdata;
  logic [SW-1:0] pstrb;
  logic [DW-1:0] prdata;
  logic          pready;
  logic          pslverr;
  logic [11:0]   device_temp;
  logic          init_calib_done;

  logic [31:0]   seed = 32'h4ae2;
  logic [DW-1:0] ref_mem [MEM_DEPTH];
  int            cycle_cnt = 0;

  ddr_ctrl_top #(
    .MEM_DEPTH(MEM_DEPTH),
    .LOCK_CYCLES(LOCK_CYCLES),
    .CALIB_CYCLES(CALIB_CYCLES),
    .REF_CYCLES(REF_CYCLES),
    .ZQ_CYCLES(ZQ_CYCLES)
  ) dut0 (
    .i_apb_clk(apb_clk),
    .i_rst_n(rst_n),
    .i_psel(psel),
    .i_penable(penable),
    .i_pwrite(pwrite),
    .i_paddr(paddr),
    .i_pwdata(pwdata),
    .i_pstrb(pstrb),
    .o_prdata(prdata),
    .o_pready(pready),
    .o_pslverr(pslverr),
    .i_device_temp(device_temp),
    .o_init_calib_done(init_calib_done)
  );

  always #10 apb_clk = ~apb_clk;

  // Run limit, about 300 transfers plus calibration and polling
  always @(posedge apb_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout after %0d clock cycles, test sequence did not finish", cycle_cnt);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped on timeout");
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [AW-1:0] mem_addr(input int idx);
    return ddr_apb_pkg::MEM_BASE + AW'(4 * idx);
  endfunction

  // Byte lanes with a set strobe take the new data
  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_word,
                                                input logic [DW-1:0] new_word,
                                                input logic [SW-1:0] strb);
    logic [DW-1:0] res;
    res = old_word;
    for (int b = 0; b < SW; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Status layout, MSB first
  function automatic ddr_regs_pkg::ddr_status_u expect_status(input logic [3:0] ref_count,
                                                              input logic [11:0] temp,
                                                              input logic zq_busy,
                                                              input logic ref_busy,
                                                              input logic calib,
                                                              input logic pll);
    ddr_regs_pkg::ddr_status_u s;
    s.raw = {ref_count, temp, 12'h000, zq_busy, ref_busy, calib, pll};
    return s;
  endfunction

  task automatic check_word(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic check_status(input ddr_regs_pkg::ddr_status_u got,
                              input ddr_regs_pkg::ddr_status_u exp, input string what);
    if (got.raw !== exp.raw) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got.raw, exp.raw);
      $display("TEST FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // One APB transfer, results sampled on the falling edge
  task automatic apb_transfer(input logic wr, input logic [AW-1:0] addr,
                              input logic [DW-1:0] wdata, input logic [SW-1:0] strb,
                              output logic [DW-1:0] rdata, output logic err);
    @(posedge apb_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    pstrb   <= strb;
    @(posedge apb_clk);
    penable <= 1'b1;
    @(negedge apb_clk);
    while (!pready) begin
      @(negedge apb_clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge apb_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [AW-1:0] addr, input logic [DW-1:0] wdata,
                           input logic [SW-1:0] strb, output logic err);
    logic [DW-1:0] unused;
    apb_transfer(1'b1, addr, wdata, strb, unused, err);
  endtask

  task automatic apb_read(input logic [AW-1:0] addr, output logic [DW-1:0] rdata,
                          output logic err);
    apb_transfer(1'b0, addr, '0, '0, rdata, err);
  endtask

  initial begin
    logic [DW-1:0]             rdata;
    logic [DW-1:0]             wdata;
    logic [SW-1:0]             strb;
    logic                      err;
    logic [11:0]               temp;
    logic [3:0]                ref_cnt_exp;
    logic [1:0]                req;
    int                        idx;
    ddr_regs_pkg::ddr_status_u stat;
    logic [AW-1:0]             bad_addr [5];

    bad_addr = '{12'h00C, 12'h0F0, 12'h002, mem_addr(MEM_DEPTH), 12'hFFC};
    seed = lcg_step(seed);
    temp = seed[27:16];
    psel        <= 1'b0;
    penable     <= 1'b0;
    pwrite      <= 1'b0;
    paddr       <= '0;
    pwdata      <= '0;
    pstrb       <= '0;
    device_temp <= temp;
    rst_n       <= 1'b0;
    repeat (3) @(posedge apb_clk);
    rst_n <= 1'b1;

    // Before calibration
    apb_read(ddr_regs_pkg::REG_STATUS, rdata, err);
    stat.raw = rdata;
    check_status(stat, expect_status(4'd0, temp, 1'b0, 1'b0, 1'b0, 1'b0), "STATUS after reset");
    apb_read(ddr_regs_pkg::REG_ID, rdata, err);
    check_bit(err, 1'b0, "ID read response");
    check_word(rdata, 32'h0DD3_0001, "ID register value");
    apb_read(mem_addr(0), rdata, err);
    check_bit(err, 1'b1, "memory read before calibration");
    check_word(rdata, '0, "memory read data before calibration");
    apb_write(mem_addr(1), 32'hA5A5_A5A5, 4'hF, err);
    check_bit(err, 1'b1, "memory write before calibration");

    do begin
      apb_read(ddr_regs_pkg::REG_STATUS, rdata, err);
      stat.raw = rdata;
    end while (!stat.fields.calib_done);
    check_status(stat, expect_status(4'd0, temp, 1'b0, 1'b0, 1'b1, 1'b1), "STATUS calibrated");
    check_bit(init_calib_done, 1'b1, "calibration done output");

    // Fill every word, then merge random strobed writes
    for (int i = 0; i < MEM_DEPTH; i++) begin
      seed = lcg_step(seed);
      ref_mem[i] = seed;
      apb_write(mem_addr(i), seed, 4'hF, err);
      check_bit(err, 1'b0, "full word write response");
    end
    for (int i = 0; i < 96; i++) begin
      seed  = lcg_step(seed);
      wdata = seed;
      seed  = lcg_step(seed);
      strb  = seed[27:24];
      idx   = int'(seed[23:16]) % MEM_DEPTH;
      ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, strb);
      apb_write(mem_addr(idx), wdata, strb, err);
      check_bit(err, 1'b0, "strobed write response");
      if (seed[30]) begin
        apb_read(mem_addr(idx), rdata, err);
        check_bit(err, 1'b0, "read after write response");
        check_word(rdata, ref_mem[idx], "read after strobed write");
      end
    end
    for (int i = 0; i < MEM_DEPTH; i++) begin
      apb_read(mem_addr(i), rdata, err);
      check_bit(err, 1'b0, "read-back response");
      check_word(rdata, ref_mem[i], "memory read-back");
    end

    foreach (bad_addr[k]) begin
      apb_read(bad_addr[k], rdata, err);
      check_bit(err, 1'b1, "unmapped read response");
      check_word(rdata, '0, "unmapped read data");
      apb_write(bad_addr[k], 32'hFFFF_FFFF, 4'hF, err);
      check_bit(err, 1'b1, "unmapped write response");
    end
    apb_read(mem_addr(0), rdata, err);
    check_word(rdata, ref_mem[0], "first word after unmapped writes");
    apb_read(mem_addr(MEM_DEPTH - 1), rdata, err);
    check_word(rdata, ref_mem[MEM_DEPTH-1], "last word after unmapped writes");

    // Refresh and ZQ cycles, a repeated request lands while busy
    ref_cnt_exp = 4'd0;
    for (int n = 0; n < 28; n++) begin
      seed = lcg_step(seed);
      req  = (seed[17:16] == 2'b00) ? 2'b01 : seed[17:16];
      temp = seed[31:20];
      device_temp <= temp;
      apb_write(ddr_regs_pkg::REG_CTRL, {30'd0, req}, 4'hF, err);
      check_bit(err, 1'b0, "CTRL write response");
      apb_read(ddr_regs_pkg::REG_CTRL, rdata, err);
      check_word(rdata, {30'd0, req}, "busy flags after request");
      if (seed[18]) begin
        apb_write(ddr_regs_pkg::REG_CTRL, {30'd0, req}, 4'hF, err);
        check_bit(err, 1'b0, "CTRL write while busy");
      end
      do begin
        apb_read(ddr_regs_pkg::REG_CTRL, rdata, err);
      end while (rdata[1:0] != 2'b00);
      if (req[0]) begin
        ref_cnt_exp = ref_cnt_exp + 4'd1;
      end
      apb_read(ddr_regs_pkg::REG_STATUS, rdata, err);
      stat.raw = rdata;
      check_status(stat, expect_status(ref_cnt_exp, temp, 1'b0, 1'b0, 1'b1, 1'b1),
                   "STATUS after maintenance cycle");
    end

    $display("TEST OK");
    $finish;
  end

endmodule : tb_ddr_ctrl

`default_nettype wire

// File: src.f
hdl/ddr_apb_pkg.sv
hdl/ddr_regs_pkg.sv
hdl/ddr_apb_slave.sv
hdl/ddr_init_seq.sv
hdl/ddr_mem_array.sv
hdl/ddr_apb_rdmux.sv
hdl/ddr_ctrl_top.sv
testbench/ddr_ctrl_chk.sv
testbench/tb_ddr_ctrl.sv
